/* build.f */
hw/rename_pkg.sv
hw/inst_fetch.sv
hw/issue_unit.sv
hw/reg_status_file.sv
hw/reorder_buffer.sv
hw/exec_pipe.sv
hw/commit_unit.sv
hw/rename_core_top.sv
bench/rename_core_assertions.sv
bench/rename_core_tb.sv

/* bench/rename_core_tb.sv */
`timescale 1ns/1ps
module rename_core_tb;
    localparam int PROGRAM_LEN = 64;
    localparam int N_FLUSH = 3;
    localparam int FLUSH_POINTS [N_FLUSH] = '{45, 130, 220};
    localparam int WATCHDOG_CYCLES = PROGRAM_LEN * 40 + 200 * N_FLUSH;
    // pc of the last instruction before HALT
    localparam logic [31:0] LAST_PC = 32'((PROGRAM_LEN - 2) * 4);

    logic                clk;
    logic                rst;
    logic                flush;
    logic                wb_cyc;
    logic                wb_stb;
    logic [31:0]         wb_adr;
    logic [31:0]         wb_dat_i;
    logic                wb_ack;
    rename_pkg::retire_t retire;
    logic                retire_valid;
    logic                halted;

    logic [31:0] mem [PROGRAM_LEN];
    logic [31:0] last_pc;
    logic        in_txn;
    logic        finished;
    int          wait_left;
    int          cycle;

    rename_core_top dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    bind rename_core_top rename_core_assertions u_checks (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_ack       (wb_ack),
        .retire       (retire),
        .retire_valid (retire_valid),
        .r0_value     (u_regs.value[0])
    );

    // mostly r0..r3 so that dependences are frequent
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 3) != 0) begin
            return 5'($urandom_range(0, 3));
        end
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] make_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [15:0] imm;
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        imm = 16'($urandom);
        if ($urandom_range(0, 1) == 0) begin
            return {rename_pkg::op_add, rd, rs1, rs2, 15'd0};
        end
        return {rename_pkg::op_addi, rd, rs1, rs2[3:0], imm};
    endfunction

    function automatic logic is_flush_cycle(input int n);
        for (int i = 0; i < N_FLUSH; i++) begin
            if (FLUSH_POINTS[i] == n) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] read_mem(input logic [31:0] adr);
        if ((adr >> 2) < PROGRAM_LEN) begin
            return mem[adr >> 2];
        end
        return {rename_pkg::op_halt, 30'd0};
    endfunction

    // wishbone slave with 0 to 3 wait cycles per read
    task automatic serve_bus();
        if (wb_cyc && wb_stb) begin
            if (!in_txn) begin
                in_txn = 1'b1;
                wait_left = $urandom_range(0, 3);
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                wb_dat_i = read_mem(wb_adr);
            end else begin
                wait_left--;
            end
        end else begin
            in_txn = 1'b0;
            wb_ack = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        in_txn    = 1'b0;
        wait_left = 0;
        finished  = 1'b0;
        last_pc   = '1;
        cycle     = 0;
        void'($urandom(59));
        for (int i = 0; i < PROGRAM_LEN - 1; i++) begin
            mem[i] = make_inst();
        end
        mem[PROGRAM_LEN - 1] = {rename_pkg::op_halt, 30'd0};
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        while (!finished) begin
            @(posedge clk);
            #5;
            cycle++;
            serve_bus();
            flush = is_flush_cycle(cycle);
            if (retire_valid) begin
                last_pc = retire.pc;
            end
            finished = halted && last_pc == LAST_PC && cycle > FLUSH_POINTS[N_FLUSH - 1];
        end
        // let the last sampled checks settle
        repeat (2) @(posedge clk);
        if (dut.u_checks.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "%0d assertion failures", dut.u_checks.fail_count);
        end
    end

    always @(negedge clk) begin
        if (dut.u_checks.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "assertion check failed at t=%0t", $time);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES + 10) @(posedge clk);
        $display("Test failed");
        $fatal(1, "timeout, HALT not reached within %0d cycles", WATCHDOG_CYCLES);
    end

endmodule

/* bench/rename_core_assertions.sv */
`timescale 1ns/1ps
module rename_core_assertions (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic [31:0]         wb_adr,
    input  logic                wb_ack,
    input  rename_pkg::retire_t retire,
    input  logic                retire_valid,
    input  logic [31:0]         r0_value
);
    logic [31:0] shadow [32];
    logic [31:0] expect_pc;
    logic [31:0] expect_value;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic [31:0] prev_adr;
    logic [4:0]  w_rd;
    logic [4:0]  w_rs1;
    logic [4:0]  w_rs2;
    int          fail_count = 0;

    assign w_rd  = retire.word[29:25];
    assign w_rs1 = retire.word[24:20];
    assign w_rs2 = retire.word[19:15];

    // reference result for the retiring word
    always_comb begin
        opnd_a = (w_rs1 == '0) ? 32'd0 : shadow[w_rs1];
        if (retire.word[31:30] == rename_pkg::op_addi) begin
            opnd_b = {{16{retire.word[15]}}, retire.word[15:0]};
        end else begin
            opnd_b = (w_rs2 == '0) ? 32'd0 : shadow[w_rs2];
        end
        expect_value = opnd_a + opnd_b;
    end

    // shadow registers advance only in retire order
    always_ff @(posedge clk) begin
        prev_adr <= wb_adr;
        if (rst) begin
            expect_pc <= '0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (retire_valid) begin
            expect_pc <= retire.pc + 32'd4;
            if (w_rd != '0) begin
                shadow[w_rd] <= expect_value;
            end
        end
    end

    value_ok: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire.value == expect_value)
        else begin
            fail_count++;
            $error("Error t=%0t retire.value expected %h actual %h", $time,
                $sampled(expect_value), $sampled(retire.value));
        end

    rd_ok: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire.rd == w_rd)
        else begin
            fail_count++;
            $error("Error t=%0t retire.rd expected %h actual %h", $time,
                $sampled(w_rd), $sampled(retire.rd));
        end

    pc_ok: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire.pc == expect_pc)
        else begin
            fail_count++;
            $error("Error t=%0t retire.pc expected %h actual %h", $time,
                $sampled(expect_pc), $sampled(retire.pc));
        end

    no_halt_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire.word[31:30] != rename_pkg::op_halt)
        else begin
            fail_count++;
            $error("a HALT word was retired at t=%0t", $time);
        end

    r0_zero: assert property (@(posedge clk) disable iff (rst) r0_value == '0)
        else begin
            fail_count++;
            $error("Error t=%0t register 0 expected 00000000 actual %h", $time,
                $sampled(r0_value));
        end

    stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else begin
            fail_count++;
            $error("wb_stb was high without wb_cyc at t=%0t", $time);
        end

    adr_stable: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> !wb_stb || wb_adr == prev_adr)
        else begin
            fail_count++;
            $error("Error t=%0t wb_adr expected %h actual %h", $time,
                $sampled(prev_adr), $sampled(wb_adr));
        end

    stb_drop: assert property (@(posedge clk) disable iff (rst) wb_stb && wb_ack |=> !wb_stb)
        else begin
            fail_count++;
            $error("wb_stb stayed high in the cycle after wb_ack at t=%0t", $time);
        end

    reset_idle: assert property (@(posedge clk) rst |=> !retire_valid && !wb_cyc && !wb_stb)
        else begin
            fail_count++;
            $error("retire_valid or the bus was active after reset at t=%0t", $time);
        end

    flush_quiet: assert property (@(posedge clk) disable iff (rst) flush |=> !retire_valid)
        else begin
            fail_count++;
            $error("retire_valid was high in the cycle after flush at t=%0t", $time);
        end

endmodule

/* hw/rename_core_top.sv */
`timescale 1ns/1ps
module rename_core_top #(
    parameter int REG_NUM   = 32,
    parameter int ROB_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic [31:0]             wb_adr,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_ack,
    output rename_pkg::retire_t     retire,
    output logic                    retire_valid,
    output logic                    halted
);
    rename_pkg::inst_t      inst;
    logic                   inst_valid;
    logic                   inst_ready;
    logic [31:0]            restart_pc;
    rename_pkg::reg_idx_t   rs1;
    rename_pkg::reg_idx_t   rs2;
    logic                   src1_busy;
    logic                   src2_busy;
    rename_pkg::rob_tag_t   src1_tag;
    rename_pkg::rob_tag_t   src2_tag;
    logic [31:0]            src1_value;
    logic [31:0]            src2_value;
    logic                   rob_full;
    rename_pkg::rob_tag_t   rob_tail;
    logic                   rob_alloc;
    rename_pkg::rob_tag_t   rob_query1;
    rename_pkg::rob_tag_t   rob_query2;
    logic                   rob_done1;
    logic                   rob_done2;
    logic [31:0]            rob_result1;
    logic [31:0]            rob_result2;
    rename_pkg::exec_req_t  exec_req;
    logic                   exec_valid;
    logic                   wb_valid;
    rename_pkg::wb_result_t wb;
    rename_pkg::rob_entry_t head;
    rename_pkg::rob_tag_t   head_tag;
    logic                   head_valid;
    logic                   pop;
    logic                   commit_valid;
    rename_pkg::reg_idx_t   commit_rd;
    rename_pkg::rob_tag_t   commit_tag;
    logic [31:0]            commit_value;

    inst_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .restart_pc (restart_pc),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready)
    );

    issue_unit u_issue (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .rs1         (rs1),
        .rs2         (rs2),
        .src1_busy   (src1_busy),
        .src2_busy   (src2_busy),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_value  (src1_value),
        .src2_value  (src2_value),
        .rob_full    (rob_full),
        .rob_tail    (rob_tail),
        .rob_alloc   (rob_alloc),
        .rob_query1  (rob_query1),
        .rob_query2  (rob_query2),
        .rob_done1   (rob_done1),
        .rob_done2   (rob_done2),
        .rob_result1 (rob_result1),
        .rob_result2 (rob_result2),
        .exec_req    (exec_req),
        .exec_valid  (exec_valid),
        .halted      (halted)
    );

    // rename uses the tail tag allocated in the same cycle
    reg_status_file #(
        .REG_NUM (REG_NUM)
    ) u_regs (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .rs1          (rs1),
        .rs2          (rs2),
        .src1_busy    (src1_busy),
        .src2_busy    (src2_busy),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .src1_value   (src1_value),
        .src2_value   (src2_value),
        .rename_valid (rob_alloc),
        .rename_rd    (inst.rd),
        .rename_tag   (rob_tail),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .commit_value (commit_value)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc_valid (rob_alloc),
        .alloc_rd    (inst.rd),
        .alloc_pc    (inst.pc),
        .alloc_word  (inst.word),
        .tail        (rob_tail),
        .full        (rob_full),
        .query1      (rob_query1),
        .query2      (rob_query2),
        .done1       (rob_done1),
        .done2       (rob_done2),
        .result1     (rob_result1),
        .result2     (rob_result2),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .head        (head),
        .head_tag    (head_tag),
        .head_valid  (head_valid),
        .pop         (pop)
    );

    exec_pipe u_exec (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req_valid (exec_valid),
        .req       (exec_req),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    commit_unit u_commit (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .head         (head),
        .head_tag     (head_tag),
        .head_valid   (head_valid),
        .pop          (pop),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .commit_value (commit_value),
        .retire       (retire),
        .retire_valid (retire_valid),
        .restart_pc   (restart_pc)
    );

endmodule

/* hw/commit_unit.sv */
`timescale 1ns/1ps
module commit_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rename_pkg::rob_entry_t  head,
    input  rename_pkg::rob_tag_t    head_tag,
    input  logic                    head_valid,
    output logic                    pop,
    output logic                    commit_valid,
    output rename_pkg::reg_idx_t    commit_rd,
    output rename_pkg::rob_tag_t    commit_tag,
    output logic [31:0]             commit_value,
    output rename_pkg::retire_t     retire,
    output logic                    retire_valid,
    output logic [31:0]             restart_pc
);
    assign pop = head_valid && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            retire_valid <= 1'b0;
            restart_pc   <= '0;
        end else begin
            commit_valid <= pop;
            retire_valid <= pop;
            if (pop) begin
                restart_pc <= head.pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            commit_rd    <= head.rd;
            commit_tag   <= head_tag;
            commit_value <= head.result;
            retire.pc    <= head.pc;
            retire.word  <= head.word;
            retire.rd    <= head.rd;
            retire.value <= head.result;
        end
    end

endmodule

/* hw/exec_pipe.sv */
`timescale 1ns/1ps
module exec_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    req_valid,
    input  rename_pkg::exec_req_t   req,
    output logic                    wb_valid,
    output rename_pkg::wb_result_t  wb
);
    logic                   s1_valid;
    logic                   s2_valid;
    rename_pkg::wb_result_t s1;
    rename_pkg::wb_result_t s2;

    assign wb_valid = s2_valid;
    assign wb       = s2;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
        end
    end

    // sum in stage one while stage two only holds it
    always_ff @(posedge clk) begin
        s1.tag    <= req.tag;
        s1.result <= req.op_a + req.op_b;
        s2        <= s1;
    end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    alloc_valid,
    input  rename_pkg::reg_idx_t    alloc_rd,
    input  logic [31:0]             alloc_pc,
    input  logic [31:0]             alloc_word,
    output rename_pkg::rob_tag_t    tail,
    output logic                    full,
    input  rename_pkg::rob_tag_t    query1,
    input  rename_pkg::rob_tag_t    query2,
    output logic                    done1,
    output logic                    done2,
    output logic [31:0]             result1,
    output logic [31:0]             result2,
    input  logic                    wb_valid,
    input  rename_pkg::wb_result_t  wb,
    output rename_pkg::rob_entry_t  head,
    output rename_pkg::rob_tag_t    head_tag,
    output logic                    head_valid,
    input  logic                    pop
);
    localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

    rename_pkg::rob_entry_t entries [ROB_DEPTH];
    rename_pkg::rob_tag_t   head_ptr;
    rename_pkg::rob_tag_t   tail_ptr;
    logic [CNT_W-1:0]       count;
    logic                   do_alloc;
    logic                   do_pop;

    function automatic rename_pkg::rob_tag_t next_ptr(input rename_pkg::rob_tag_t p);
        if (p == rename_pkg::rob_tag_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full       = count == CNT_W'(ROB_DEPTH);
    assign tail       = tail_ptr;
    assign head       = entries[head_ptr];
    assign head_tag   = head_ptr;
    assign head_valid = count != '0 && entries[head_ptr].done;

    // popped slots keep their result until reallocated
    assign done1   = entries[query1].done;
    assign done2   = entries[query2].done;
    assign result1 = entries[query1].result;
    assign result2 = entries[query2].result;

    assign do_alloc = alloc_valid && !full;
    assign do_pop   = pop && head_valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_alloc) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (do_pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            count <= count + CNT_W'(do_alloc) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            entries[wb.tag].done   <= 1'b1;
            entries[wb.tag].result <= wb.result;
        end
        if (do_alloc) begin
            entries[tail_ptr].done   <= 1'b0;
            entries[tail_ptr].rd     <= alloc_rd;
            entries[tail_ptr].result <= '0;
            entries[tail_ptr].pc     <= alloc_pc;
            entries[tail_ptr].word   <= alloc_word;
        end
    end

endmodule

/* hw/reg_status_file.sv */
`timescale 1ns/1ps
module reg_status_file #(
    parameter int REG_NUM = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rename_pkg::reg_idx_t    rs1,
    input  rename_pkg::reg_idx_t    rs2,
    output logic                    src1_busy,
    output logic                    src2_busy,
    output rename_pkg::rob_tag_t    src1_tag,
    output rename_pkg::rob_tag_t    src2_tag,
    output logic [31:0]             src1_value,
    output logic [31:0]             src2_value,
    input  logic                    rename_valid,
    input  rename_pkg::reg_idx_t    rename_rd,
    input  rename_pkg::rob_tag_t    rename_tag,
    input  logic                    commit_valid,
    input  rename_pkg::reg_idx_t    commit_rd,
    input  rename_pkg::rob_tag_t    commit_tag,
    input  logic [31:0]             commit_value
);
    logic [31:0]          value [REG_NUM];
    rename_pkg::rob_tag_t tag   [REG_NUM];
    logic [REG_NUM-1:0]   busy;
    logic                 do_rename;
    logic                 do_commit;

    // register 0 never goes busy
    assign src1_busy  = busy[rs1];
    assign src2_busy  = busy[rs2];
    assign src1_tag   = tag[rs1];
    assign src2_tag   = tag[rs2];
    assign src1_value = value[rs1];
    assign src2_value = value[rs2];

    assign do_rename = rename_valid && rename_rd != '0;
    assign do_commit = commit_valid && commit_rd != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < REG_NUM; i++) begin
                value[i] <= '0;
            end
        end else begin
            // retired values survive a flush
            if (do_commit) begin
                value[commit_rd] <= commit_value;
            end
            if (flush) begin
                busy <= '0;
            end else begin
                if (do_commit && tag[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
                // a rename in the same cycle wins
                if (do_rename) begin
                    busy[rename_rd] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_rename) begin
            tag[rename_rd] <= rename_tag;
        end
    end

endmodule

/* hw/issue_unit.sv */
`timescale 1ns/1ps
module issue_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rename_pkg::inst_t       inst,
    input  logic                    inst_valid,
    output logic                    inst_ready,
    output rename_pkg::reg_idx_t    rs1,
    output rename_pkg::reg_idx_t    rs2,
    input  logic                    src1_busy,
    input  logic                    src2_busy,
    input  rename_pkg::rob_tag_t    src1_tag,
    input  rename_pkg::rob_tag_t    src2_tag,
    input  logic [31:0]             src1_value,
    input  logic [31:0]             src2_value,
    input  logic                    rob_full,
    input  rename_pkg::rob_tag_t    rob_tail,
    output logic                    rob_alloc,
    output rename_pkg::rob_tag_t    rob_query1,
    output rename_pkg::rob_tag_t    rob_query2,
    input  logic                    rob_done1,
    input  logic                    rob_done2,
    input  logic [31:0]             rob_result1,
    input  logic [31:0]             rob_result2,
    output rename_pkg::exec_req_t   exec_req,
    output logic                    exec_valid,
    output logic                    halted
);
    logic        is_halt;
    logic        is_addi;
    logic [32:0] opnd1;
    logic [32:0] opnd2;
    logic        srcs_ok;

    // msb is the ready flag
    function automatic logic [32:0] pick_operand(input rename_pkg::reg_idx_t idx,
            input logic busy, input logic [31:0] value, input logic done,
            input logic [31:0] result);
        if (idx == '0) begin
            return {1'b1, 32'd0};
        end else if (!busy) begin
            return {1'b1, value};
        end else if (done) begin
            return {1'b1, result};
        end
        return {1'b0, 32'd0};
    endfunction

    assign rs1        = inst.rs1;
    assign rs2        = inst.rs2;
    assign rob_query1 = src1_tag;
    assign rob_query2 = src2_tag;

    assign is_halt = inst.opcode == rename_pkg::op_halt;
    assign is_addi = inst.opcode == rename_pkg::op_addi;
    assign opnd1   = pick_operand(inst.rs1, src1_busy, src1_value, rob_done1, rob_result1);
    assign opnd2   = pick_operand(inst.rs2, src2_busy, src2_value, rob_done2, rob_result2);
    assign srcs_ok = opnd1[32] && (is_addi || opnd2[32]);

    // HALT needs no entry and no operands
    assign inst_ready = !halted && !flush && (is_halt || (!rob_full && srcs_ok));
    assign rob_alloc  = inst_valid && inst_ready && !is_halt;
    assign exec_valid = rob_alloc;

    assign exec_req.tag  = rob_tail;
    assign exec_req.op_a = opnd1[31:0];
    assign exec_req.op_b = is_addi ? {{16{inst.imm[15]}}, inst.imm} : opnd2[31:0];
    assign exec_req.pc   = inst.pc;
    assign exec_req.word = inst.word;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            halted <= 1'b0;
        end else if (inst_valid && inst_ready && is_halt) begin
            halted <= 1'b1;
        end
    end

endmodule

/* hw/inst_fetch.sv */
`timescale 1ns/1ps
module inst_fetch (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic [31:0]         restart_pc,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic [31:0]         wb_adr,
    input  logic [31:0]         wb_dat_i,
    input  logic                wb_ack,
    output rename_pkg::inst_t   inst,
    output logic                inst_valid,
    input  logic                inst_ready
);
    logic [31:0] pc;
    logic        cyc;
    logic        hold_valid;
    logic        stopped;

    assign wb_cyc     = cyc;
    assign wb_stb     = cyc;
    assign wb_adr     = pc;
    assign inst_valid = hold_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc        <= 1'b0;
            hold_valid <= 1'b0;
            stopped    <= 1'b0;
            pc         <= '0;
        end else if (flush) begin
            // open cycle is dropped so a late ack finds cyc low
            cyc        <= 1'b0;
            hold_valid <= 1'b0;
            stopped    <= 1'b0;
            pc         <= restart_pc;
        end else begin
            if (cyc && wb_ack) begin
                cyc        <= 1'b0;
                pc         <= pc + 32'd4;
                hold_valid <= 1'b1;
                stopped    <= wb_dat_i[31:30] == rename_pkg::op_halt;
            end else if (!cyc && !hold_valid && !stopped) begin
                cyc <= 1'b1;
            end
            if (hold_valid && inst_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // decode into the holding register
    always_ff @(posedge clk) begin
        if (cyc && wb_ack) begin
            inst.opcode <= wb_dat_i[31:30];
            inst.rd     <= wb_dat_i[29:25];
            inst.rs1    <= wb_dat_i[24:20];
            inst.rs2    <= wb_dat_i[19:15];
            inst.imm    <= wb_dat_i[15:0];
            inst.word   <= wb_dat_i;
            inst.pc     <= pc;
        end
    end

endmodule

/* hw/rename_pkg.sv */
package rename_pkg;

    typedef logic [4:0] reg_idx_t;
    // must be $clog2(ROB_DEPTH) bits wide
    typedef logic [2:0] rob_tag_t;

    // opcode field sits in word bits 31..30
    localparam logic [1:0] op_add  = 2'd0;
    localparam logic [1:0] op_addi = 2'd1;
    localparam logic [1:0] op_halt = 2'd2;

    // rd 29..25, rs1 24..20, rs2 19..15, imm 15..0 (imm overlaps rs2 on ADDI)
    typedef struct packed {
        logic [1:0]  opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [15:0] imm;
        logic [31:0] word;
        logic [31:0] pc;
    } inst_t;

    typedef struct packed {
        rob_tag_t    tag;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] pc;
        logic [31:0] word;
    } exec_req_t;

    typedef struct packed {
        rob_tag_t    tag;
        logic [31:0] result;
    } wb_result_t;

    typedef struct packed {
        logic        done;
        reg_idx_t    rd;
        logic [31:0] result;
        logic [31:0] pc;
        logic [31:0] word;
    } rob_entry_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        reg_idx_t    rd;
        logic [31:0] value;
    } retire_t;

endpackage
